// File: common/busctl_pkg.sv
package busctl_pkg;

    localparam int MASTER_COUNT = 2;  // internal masters
    localparam int SLAVE_COUNT = 3;
    localparam int CONFIG_CLKS = 2;   // cycles spent in each loading step

    localparam int unsigned SLAVE_DEPTHS [SLAVE_COUNT] = '{4096, 4096, 2048};

    typedef logic [1:0] slave_id_t;   // 0 = no slave, 1..3 select a slave
    typedef logic [$clog2(MASTER_COUNT)-1:0] master_id_t;

    typedef enum logic [3:0] {
        master_slave_sel,
        read_write_sel,
        external_write_sel,
        external_write_m1,
        external_write_m2,
        external_write_m1_2,
        start_addr_m1,
        start_addr_m2,
        end_addr_m1,
        end_addr_m2,
        config_masters,
        communication_ready,
        communicating,
        communication_done
    } main_state_t;

    typedef enum logic [1:0] {
        config_start,
        config_middle,
        config_last,
        config_done
    } config_state_t;

    function automatic int unsigned slave_depth(input slave_id_t id);
        if (id == '0) begin
            return SLAVE_DEPTHS[0];  // unselected master is never loaded
        end
        return SLAVE_DEPTHS[id - 1'b1];
    endfunction

endpackage

// File: hw/setup_fsm/setup_fsm.sv
`timescale 1ns/100ps

module setup_fsm import busctl_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 12
) (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic [17:0]                            sw,
    input  logic                                   step,
    input  logic                                   next_addr,
    input  logic [MASTER_COUNT-1:0]                done_com,
    input  logic                                   go,
    input  logic                                   cfg_done,
    output main_state_t                            phase,
    output slave_id_t [MASTER_COUNT-1:0]           m_slave_id,
    output logic [MASTER_COUNT-1:0]                m_rd_wr,
    output logic [MASTER_COUNT-1:0]                m_in_ex,
    output logic [MASTER_COUNT-1:0]                m_burst,
    output logic [MASTER_COUNT-1:0]                m_eoc,
    output logic                                   wr_en,
    output master_id_t                             wr_master,
    output logic [DATA_WIDTH-1:0]                  wr_data,
    output logic                                   clear_ptr,
    output logic                                   cfg_go,
    output logic                                   comm_go,
    output logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0] first_addr,
    output logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0] last_addr
);

    main_state_t state, nxt_state;
    logic in_write;
    logic com_over;

    // end address of a burst, held inside the selected slave
    function automatic logic [ADDR_WIDTH-1:0] clamp_last(
        input logic [ADDR_WIDTH-1:0] first,
        input logic [ADDR_WIDTH-1:0] len,
        input slave_id_t id
    );
        logic [ADDR_WIDTH:0] sum;
        int unsigned depth;
        sum = {1'b0, first} + {1'b0, len};
        depth = slave_depth(id);
        if (32'(sum) >= depth) begin
            return ADDR_WIDTH'(depth - 1);
        end
        return sum[ADDR_WIDTH-1:0];
    endfunction

    assign in_write = state inside {external_write_m1, external_write_m2, external_write_m1_2};
    assign wr_master = master_id_t'(state == external_write_m2);
    assign wr_en = in_write & (step | next_addr);   // step also stores the last word
    assign wr_data = sw[DATA_WIDTH-1:0];
    assign clear_ptr = in_write & step;
    assign cfg_go = (state == end_addr_m2) & step;
    assign comm_go = (state == communication_ready) & go;
    assign phase = state;

    // a master with no slave only waits on the other one
    assign com_over = (&done_com)
                    | ((m_slave_id[0] == '0) & done_com[1])
                    | ((m_slave_id[1] == '0) & done_com[0]);

    always_comb begin
        nxt_state = state;
        case (state)
            master_slave_sel: begin
                if (step) begin
                    nxt_state = (sw[3:0] == '0) ? communication_done : read_write_sel;
                end
            end
            read_write_sel:      if (step) nxt_state = external_write_sel;
            external_write_sel: begin
                if (step) begin
                    case (sw[1:0])
                        2'b01:   nxt_state = external_write_m1;
                        2'b10:   nxt_state = external_write_m2;
                        2'b11:   nxt_state = external_write_m1_2;
                        default: nxt_state = start_addr_m1;  // both internal
                    endcase
                end
            end
            external_write_m1:   if (step) nxt_state = start_addr_m1;
            external_write_m1_2: if (step) nxt_state = external_write_m2;
            external_write_m2:   if (step) nxt_state = start_addr_m1;
            start_addr_m1:       if (step) nxt_state = start_addr_m2;
            start_addr_m2:       if (step) nxt_state = end_addr_m1;
            end_addr_m1:         if (step) nxt_state = end_addr_m2;
            end_addr_m2:         if (step) nxt_state = config_masters;
            config_masters:      if (cfg_done) nxt_state = communication_ready;
            communication_ready: if (go) nxt_state = communicating;
            communicating:       if (com_over) nxt_state = communication_done;
            default:             nxt_state = state;  // done holds until reset
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= master_slave_sel;
            m_slave_id <= '0;
            m_rd_wr <= '0;
            m_in_ex <= '0;
            m_burst <= '0;
            m_eoc <= '0;
            first_addr <= '0;
            last_addr <= '0;
        end else begin
            state <= nxt_state;
            m_eoc <= '0;
            if (step) begin
                case (state)
                    master_slave_sel: begin
                        for (int i = 0; i < MASTER_COUNT; i++) begin
                            m_slave_id[i] <= slave_id_t'(sw[2*i +: 2]);
                        end
                        if (sw[3:0] == '0) begin
                            m_eoc <= '1;  // nothing to do, release both masters
                        end
                    end
                    read_write_sel:     m_rd_wr <= sw[MASTER_COUNT-1:0];
                    external_write_sel: m_in_ex <= sw[MASTER_COUNT-1:0];
                    start_addr_m1:      first_addr[0] <= sw[ADDR_WIDTH-1:0];
                    start_addr_m2:      first_addr[1] <= sw[ADDR_WIDTH-1:0];
                    end_addr_m1: begin
                        last_addr[0] <= clamp_last(first_addr[0], sw[ADDR_WIDTH-1:0],
                                                   m_slave_id[0]);
                    end
                    end_addr_m2: begin
                        last_addr[1] <= clamp_last(first_addr[1], sw[ADDR_WIDTH-1:0],
                                                   m_slave_id[1]);
                    end
                    default: ;
                endcase
            end
            if (in_write && next_addr && !step) begin
                m_burst[wr_master] <= 1'b1;  // more than one word for this master
            end
        end
    end

endmodule

// File: hw/data_bank/data_bank.sv
`timescale 1ns/100ps

module data_bank import busctl_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int BANK_DEPTH = 16,
    localparam int PTR_W = $clog2(BANK_DEPTH),
    localparam int CNT_W = $clog2(BANK_DEPTH + 1)
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  wr_en,
    input  master_id_t            wr_master,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic                  clear_ptr,
    input  master_id_t            rd_master,
    input  logic [PTR_W-1:0]      rd_index,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic [CNT_W-1:0]      wr_count
);

    logic [DATA_WIDTH-1:0] mem [MASTER_COUNT][BANK_DEPTH];
    logic [PTR_W-1:0] wr_ptr;                     // shared by both masters
    logic [MASTER_COUNT-1:0][CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_master][wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (clear_ptr) begin
                wr_ptr <= '0;  // next master starts at word 0
            end else if (wr_en && wr_ptr != PTR_W'(BANK_DEPTH - 1)) begin
                wr_ptr <= wr_ptr + 1'b1;  // last location is reused when full
            end
            if (wr_en && count[wr_master] != CNT_W'(BANK_DEPTH)) begin
                count[wr_master] <= count[wr_master] + 1'b1;
            end
        end
    end

    assign rd_data = mem[rd_master][rd_index];
    assign wr_count = count[rd_master];

endmodule

// File: hw/config_sequencer/config_sequencer.sv
`timescale 1ns/100ps

module config_sequencer import busctl_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 12,
    parameter int BANK_DEPTH = 16,
    localparam int PTR_W = $clog2(BANK_DEPTH),
    localparam int CNT_W = $clog2(BANK_DEPTH + 1)
) (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic                                   cfg_go,
    input  logic                                   comm_go,
    input  logic [MASTER_COUNT-1:0]                in_ex,
    input  logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0] first_addr,
    input  logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0] last_addr,
    input  logic [CNT_W-1:0]                       wr_count,
    input  logic [DATA_WIDTH-1:0]                  rd_data,
    output master_id_t                             rd_master,
    output logic [PTR_W-1:0]                       rd_index,
    output logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0] m_address,
    output logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0] m_data,
    output logic [MASTER_COUNT-1:0]                m_start,
    output logic                                   cfg_done
);

    localparam int CLK_W = $clog2(CONFIG_CLKS + 1);

    config_state_t cfg_state, nxt_state;
    master_id_t cur_master;
    logic [CLK_W-1:0] clk_cnt;
    logic [PTR_W-1:0] word_idx;
    logic [CNT_W-1:0] n_words;
    logic step_end;
    logic new_step;
    logic load;

    assign step_end = (clk_cnt == CLK_W'(CONFIG_CLKS - 1));
    assign new_step = (cfg_state == config_done) ? cfg_go : step_end;
    assign load = new_step && (nxt_state != config_done);

    // internal data or an empty bank loads a single word
    assign n_words = (in_ex[rd_master] && wr_count != '0) ? wr_count : CNT_W'(1);

    // nxt_state, rd_master and rd_index describe the step that follows this one
    always_comb begin
        nxt_state = cfg_state;
        rd_master = cur_master;
        rd_index = word_idx;
        case (cfg_state)
            config_done: begin
                nxt_state = config_start;
                rd_master = '0;
                rd_index = '0;
            end
            config_start, config_middle: begin
                if (CNT_W'(word_idx) + CNT_W'(2) >= n_words) begin
                    nxt_state = config_last;
                    rd_index = (n_words > CNT_W'(1)) ? word_idx + 1'b1 : '0;
                end else begin
                    nxt_state = config_middle;
                    rd_index = word_idx + 1'b1;
                end
            end
            default: begin
                rd_master = master_id_t'(cur_master + 1'b1);
                rd_index = '0;
                nxt_state = (cur_master == master_id_t'(MASTER_COUNT - 1)) ? config_done
                                                                           : config_start;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfg_state <= config_done;
            cur_master <= '0;
            clk_cnt <= '0;
            word_idx <= '0;
            m_start <= '0;
            cfg_done <= 1'b0;
        end else begin
            m_start <= {MASTER_COUNT{comm_go}};  // joint start of communication
            cfg_done <= new_step && (nxt_state == config_done);
            if (new_step) begin
                cfg_state <= nxt_state;
                clk_cnt <= '0;
            end else if (cfg_state != config_done) begin
                clk_cnt <= clk_cnt + 1'b1;
            end
            if (load) begin
                cur_master <= rd_master;
                word_idx <= rd_index;
                if (nxt_state != config_middle) begin
                    m_start[rd_master] <= 1'b1;  // first and last step are flagged
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            m_data[rd_master] <= rd_data;
            m_address[rd_master] <= (nxt_state == config_start) ? first_addr[rd_master]
                                                                : last_addr[rd_master];
        end
    end

endmodule

// File: hw/bus_setup_top.sv
`timescale 1ns/100ps

module bus_setup_top import busctl_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 12,
    parameter int BANK_DEPTH = 16,
    localparam int PTR_W = $clog2(BANK_DEPTH),
    localparam int CNT_W = $clog2(BANK_DEPTH + 1)
) (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic [17:0]                            sw,
    input  logic                                   step,
    input  logic                                   next_addr,
    input  logic                                   go,
    input  logic [MASTER_COUNT-1:0]                done_com,
    output main_state_t                            phase,
    output slave_id_t [MASTER_COUNT-1:0]           m_slave_id,
    output logic [MASTER_COUNT-1:0]                m_rd_wr,
    output logic [MASTER_COUNT-1:0]                m_in_ex,
    output logic [MASTER_COUNT-1:0]                m_burst,
    output logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0] m_address,
    output logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0] m_data,
    output logic [MASTER_COUNT-1:0]                m_start,
    output logic [MASTER_COUNT-1:0]                m_eoc
);

    logic wr_en;
    master_id_t wr_master;
    logic [DATA_WIDTH-1:0] wr_data;
    logic clear_ptr;
    logic cfg_go;
    logic comm_go;
    logic cfg_done;
    logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0] first_addr;
    logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0] last_addr;
    master_id_t rd_master;
    logic [PTR_W-1:0] rd_index;
    logic [DATA_WIDTH-1:0] rd_data;
    logic [CNT_W-1:0] wr_count;

    setup_fsm #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) setup_fsm_i (
        .clk, .rstN,
        .sw, .step, .next_addr, .done_com, .go, .cfg_done,
        .phase,
        .m_slave_id, .m_rd_wr, .m_in_ex, .m_burst, .m_eoc,
        .wr_en, .wr_master, .wr_data, .clear_ptr,
        .cfg_go, .comm_go, .first_addr, .last_addr
    );

    data_bank #(
        .DATA_WIDTH(DATA_WIDTH),
        .BANK_DEPTH(BANK_DEPTH)
    ) data_bank_i (
        .clk, .rstN,
        .wr_en, .wr_master, .wr_data, .clear_ptr,
        .rd_master, .rd_index,
        .rd_data, .wr_count
    );

    config_sequencer #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .BANK_DEPTH(BANK_DEPTH)
    ) config_sequencer_i (
        .clk, .rstN,
        .cfg_go, .comm_go,
        .in_ex(m_in_ex), .first_addr, .last_addr,
        .wr_count, .rd_data,
        .rd_master, .rd_index,
        .m_address, .m_data, .m_start,
        .cfg_done
    );

endmodule

// File: bench/bus_setup_properties.sv
`timescale 1ns/100ps

module bus_setup_properties import busctl_pkg::*; (
    input logic                    clk,
    input logic                    rstN,
    input logic [MASTER_COUNT-1:0] m_start,
    input logic                    cfg_done
);

    int unsigned assert_fails = 0;  // failed assertion count

    // every start, load or joint, lasts a single cycle
    start0_single: assert property (@(posedge clk) disable iff (!rstN) m_start[0] |=> !m_start[0])
        else begin
            assert_fails++;
            $error("m_start[0] high for two cycles in a row");
        end

    start1_single: assert property (@(posedge clk) disable iff (!rstN) m_start[1] |=> !m_start[1])
        else begin
            assert_fails++;
            $error("m_start[1] high for two cycles in a row");
        end

    cfg_done_single: assert property (@(posedge clk) disable iff (!rstN) cfg_done |=> !cfg_done)
        else begin
            assert_fails++;
            $error("cfg_done longer than one cycle");
        end

    no_start_in_reset: assert property (@(posedge clk) !rstN |-> m_start == '0)
        else begin
            assert_fails++;
            $error("m_start pulse while in reset");
        end

endmodule

bind config_sequencer bus_setup_properties props_i (
    .clk(clk),
    .rstN(rstN),
    .m_start(m_start),
    .cfg_done(cfg_done)
);

// File: bench/tb_bus_setup.sv
`timescale 1ns/100ps

module tb_bus_setup import busctl_pkg::*;;

    localparam int DATA_WIDTH = 16;
    localparam int ADDR_WIDTH = 12;
    localparam int CLK_PERIOD = 20;
    localparam int TEST_CYCLES = 80;  // worst case of one test with a full load
    localparam int NUM_TESTS = 6;

    logic clk;
    logic rstN;
    logic [17:0] sw;
    logic step;
    logic next_addr;
    logic go;
    logic [MASTER_COUNT-1:0] done_com;
    main_state_t phase;
    slave_id_t [MASTER_COUNT-1:0] m_slave_id;
    logic [MASTER_COUNT-1:0] m_rd_wr;
    logic [MASTER_COUNT-1:0] m_in_ex;
    logic [MASTER_COUNT-1:0] m_burst;
    logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0] m_address;
    logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0] m_data;
    logic [MASTER_COUNT-1:0] m_start;
    logic [MASTER_COUNT-1:0] m_eoc;
    integer seed = 58;
    logic [DATA_WIDTH-1:0] words [MASTER_COUNT][4];  // words typed in, per master

    bus_setup_top #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .BANK_DEPTH(16)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_TESTS * TEST_CYCLES + 100) * CLK_PERIOD);
        $display("ERROR: the tests did not finish in the expected time");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "mismatch");
    endtask

    task automatic compare_phase(input string name, input main_state_t exp, input main_state_t act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected %s, actual %s", name, exp.name(), act.name()));
    endtask

    task automatic compare_word(input string name, input logic [DATA_WIDTH-1:0] exp,
                                input logic [DATA_WIDTH-1:0] act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic compare_addr(input string name, input logic [ADDR_WIDTH-1:0] exp,
                                input logic [ADDR_WIDTH-1:0] act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic compare_id(input string name, input slave_id_t exp, input slave_id_t act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
    endtask

    // slave 3 is 2048 words deep, the others 4096
    function automatic logic [ADDR_WIDTH-1:0] expected_last(input logic [ADDR_WIDTH-1:0] first,
            input logic [ADDR_WIDTH-1:0] len, input slave_id_t id);
        int depth;
        int sum;
        depth = (id == 2'd3) ? 2048 : 4096;
        sum = int'(first) + int'(len);
        return (sum >= depth) ? ADDR_WIDTH'(depth - 1) : ADDR_WIDTH'(sum);
    endfunction

    task automatic reset_dut();
        rstN = 1'b0;
        sw = '0;
        step = 1'b0;
        next_addr = 1'b0;
        go = 1'b0;
        done_com = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic press(input logic [17:0] value, input bit is_step);
        sw = value;
        step = is_step;
        next_addr = !is_step;
        @(negedge clk);
        step = 1'b0;
        next_addr = 1'b0;
    endtask

    // starts on the first cycle of the master's config_start step
    task automatic check_load(input string name, input int m, input int n, input bit with_data,
                              input logic [ADDR_WIDTH-1:0] first, input logic [ADDR_WIDTH-1:0] last);
        int steps;
        int idx;
        steps = (n < 2) ? 2 : n;
        for (int s = 0; s < steps; s++) begin
            idx = (n == 1) ? 0 : s;  // a single word is sent twice
            for (int c = 0; c < CONFIG_CLKS; c++) begin
                compare_bit(name, (c == 0) && (s == 0 || s == steps - 1), m_start[m]);
                compare_addr(name, (s == 0) ? first : last, m_address[m]);
                if (with_data)
                    compare_word(name, words[m][idx], m_data[m]);
                @(negedge clk);
            end
        end
    endtask

    task automatic run_setup(input string name, input slave_id_t id0, input slave_id_t id1,
                             input logic [1:0] ext, input int n0, input int n1,
                             input logic [ADDR_WIDTH-1:0] first0, first1, len0, len1);
        logic [17:0] value;
        int count [MASTER_COUNT];
        count[0] = ext[0] ? n0 : 1;
        count[1] = ext[1] ? n1 : 1;
        value = 18'($random(seed));
        press({value[17:4], id1, id0}, 1'b1);
        compare_id(name, id0, m_slave_id[0]);
        compare_id(name, id1, m_slave_id[1]);
        value = 18'($random(seed));
        press(value, 1'b1);
        compare_bit(name, value[0], m_rd_wr[0]);
        compare_bit(name, value[1], m_rd_wr[1]);
        press({16'($random(seed)), ext}, 1'b1);
        compare_bit(name, ext[0], m_in_ex[0]);
        compare_bit(name, ext[1], m_in_ex[1]);
        for (int m = 0; m < MASTER_COUNT; m++) begin
            for (int k = 0; ext[m] && k < count[m]; k++) begin
                words[m][k] = DATA_WIDTH'($random(seed));
                press({2'b00, words[m][k]}, k == count[m] - 1);  // step stores the last word
            end
            compare_bit(name, count[m] > 1, m_burst[m]);
        end
        compare_phase(name, start_addr_m1, phase);
        press({6'd0, first0}, 1'b1);
        press({6'd0, first1}, 1'b1);
        press({6'd0, len0}, 1'b1);
        press({6'd0, len1}, 1'b1);
        check_load(name, 0, count[0], ext[0], first0, expected_last(first0, len0, id0));
        check_load(name, 1, count[1], ext[1], first1, expected_last(first1, len1, id1));
        compare_phase(name, config_masters, phase);
        @(negedge clk);
        compare_phase(name, communication_ready, phase);
    endtask

    task automatic start_comm(input string name);
        go = 1'b1;
        @(negedge clk);
        go = 1'b0;
        compare_bit(name, 1'b1, m_start[0]);
        compare_bit(name, 1'b1, m_start[1]);
        compare_phase(name, communicating, phase);
        @(negedge clk);
        compare_bit(name, 1'b0, |m_start);
    endtask

    task automatic test_reset_state();
        reset_dut();
        compare_phase("reset_state", master_slave_sel, phase);
        compare_bit("reset_state", 1'b0, |{m_start, m_eoc});
    endtask

    task automatic test_no_slave();
        logic [17:0] value;
        reset_dut();
        value = 18'($random(seed));
        press({value[17:4], 4'h0}, 1'b1);
        compare_phase("no_slave", communication_done, phase);
        compare_bit("no_slave", 1'b1, m_eoc[0]);
        compare_bit("no_slave", 1'b1, m_eoc[1]);
        compare_bit("no_slave", 1'b0, |m_start);
        @(negedge clk);
        compare_bit("no_slave", 1'b0, |{m_start, m_eoc});
    endtask

    task automatic test_internal_read();
        reset_dut();
        // 2000 + 100 runs past the end of slave 3
        run_setup("internal_read", 2'd1, 2'd3, 2'b00, 1, 1, ADDR_WIDTH'($random(seed)), 12'd2000,
                  ADDR_WIDTH'($random(seed)), 12'd100);
    endtask

    task automatic test_external_burst();
        slave_id_t id0;
        slave_id_t id1;
        reset_dut();
        id0 = slave_id_t'($random(seed));
        id1 = slave_id_t'($random(seed));
        run_setup("external_burst", (id0 == 0) ? 2'd3 : id0, (id1 == 0) ? 2'd1 : id1, 2'b11,
                  1 + ($random(seed) & 3), 1 + ($random(seed) & 3), ADDR_WIDTH'($random(seed)),
                  ADDR_WIDTH'($random(seed)), ADDR_WIDTH'($random(seed)),
                  ADDR_WIDTH'($random(seed)));
    endtask

    task automatic test_comm_both();
        reset_dut();
        run_setup("comm_both", 2'd2, 2'd1, 2'b00, 1, 1, 12'h100, 12'h200, 12'h00f, 12'h01f);
        start_comm("comm_both");
        done_com = 2'b01;
        @(negedge clk);
        compare_phase("comm_both", communicating, phase);  // master 1 still busy
        done_com = 2'b11;
        @(negedge clk);
        compare_phase("comm_both", communication_done, phase);
    endtask

    task automatic test_single_slave();
        reset_dut();
        run_setup("single_slave", 2'd2, 2'd0, 2'b00, 1, 1, 12'h010, 12'h020, 12'h004, 12'h008);
        start_comm("single_slave");
        done_com = 2'b01;
        @(negedge clk);
        compare_phase("single_slave", communication_done, phase);
    endtask

    initial begin
        test_reset_state();
        test_no_slave();
        test_internal_read();
        test_external_burst();
        test_comm_both();
        test_single_slave();
        if (dut_i.config_sequencer_i.props_i.assert_fails == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("ERROR: assertions on the config sequencer failed");
            $display("Checks failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: sources.f
common/busctl_pkg.sv
hw/setup_fsm/setup_fsm.sv
hw/data_bank/data_bank.sv
hw/config_sequencer/config_sequencer.sv
hw/bus_setup_top.sv
bench/bus_setup_properties.sv
bench/tb_bus_setup.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_bus_setup
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(RUN_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
